//--- project.f
adc_pkg.sv
frame_align_fsm.sv
word_phase_ctr.sv
fclk_monitor.sv
lane_gearbox.sv
sample_fifo.sv
adc_unit_top.sv
adc_unit_asserts.sv
tb_adc_unit.sv

//--- Makefile
SIM = obj_dir/Vtb_adc_unit

all: run

$(SIM): project.f $(wildcard *.sv)
	verilator --binary --assert --top-module tb_adc_unit -f project.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- tb_adc_unit.sv
`timescale 1ns/1ps

module tb_adc_unit;

  import adc_pkg::*;

  logic      lclk_d4;
  logic      rst_n;
  logic      sync;
  logic      rd_en;
  group_t    fclk4b;
  logic [7:0] din4b;
  logic      locked;
  err_cnt_t  fclk_err_cnt;
  sample_t   dout_ch0;
  sample_t   dout_ch1;
  logic      dout_odd;
  logic      empty;
  logic      full;

  logic [20:0] exp_q [$];   // {odd, ch1, ch0} in fifo order
  group_t      fclk_seq [5];
  logic [31:0] rng;
  bit          aligned;     // frame boundary known to the model
  bit          saw_unlock;
  int          errors;
  int          test_err0;
  int          tests_ok;
  int          tests_bad;
  err_cnt_t    err0;

  adc_unit_top #(.FIFO_DEPTH(8)) i_adc_unit_top (
    .lclk_d4 (lclk_d4), .rst_n (rst_n), .sync (sync), .fclk4b (fclk4b),
    .din4b (din4b), .rd_en (rd_en), .locked (locked), .fclk_err_cnt (fclk_err_cnt),
    .dout_ch0 (dout_ch0), .dout_ch1 (dout_ch1), .dout_odd (dout_odd),
    .empty (empty), .full (full)
  );

  always #10 lclk_d4 = ~lclk_d4;

  always @(negedge lclk_d4) if (!locked) saw_unlock = 1'b1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input string what, input bit cond);
    assert (cond) else begin
      $display("t=%0t check failed: %s", $time, what);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_err0) tests_ok++;
    else tests_bad++;
    $display("test %s: %s", name, (errors == test_err0) ? "ok" : "bad");
    test_err0 = errors;
  endtask

  // sends one frame from start_ph on with an optional sync and bad fclk group
  task automatic send_frame(input int start_ph, input int sync_at, input int bad_at);
    sample_t d0 [2];
    sample_t d1 [2];
    group_t  g [2];
    bit      cap;
    cap = aligned && (start_ph == 0) && (sync_at < 0); // dut locked for the whole frame
    for (int i = 0; i < 2; i++) begin
      rng   = xorshift(rng);
      d0[i] = rng[9:0];
      d1[i] = rng[25:16];
    end
    for (int ph = start_ph; ph < 5; ph++) begin
      for (int i = 0; i < 2; i++) begin
        case (ph)
          0: g[i] = d0[i][3:0];
          1: g[i] = d0[i][7:4];
          2: g[i] = {d1[i][1:0], d0[i][9:8]};
          3: g[i] = d1[i][5:2];
          default: g[i] = d1[i][9:6];
        endcase
      end
      @(posedge lclk_d4);
      fclk4b <= (ph == bad_at) ? 4'b1010 : fclk_seq[ph];
      din4b  <= {g[1], g[0]};
      sync   <= (ph == sync_at);
    end
    aligned = 1'b1;  // the G4 just sent sets the boundary
    // no pops while sending so the fifo of 8 drops the newest pairs once full
    if (cap && exp_q.size() < 8) exp_q.push_back({1'b0, d0[1], d0[0]});
    if (cap && exp_q.size() < 8) exp_q.push_back({1'b1, d1[1], d1[0]});
  endtask

  // hold sync so nothing more is written while draining
  task automatic park();
    @(posedge lclk_d4);
    sync    <= 1'b1;
    fclk4b  <= FCLK_G1;
    din4b   <= '0;
    aligned = 1'b0;
    repeat (3) @(posedge lclk_d4);
  endtask

  task automatic drain();
    logic [20:0] e;
    int guard;
    guard = 0;
    @(negedge lclk_d4);
    while (!empty && guard < 64) begin
      check_true("fifo holds more entries than expected", exp_q.size() > 0);
      e = (exp_q.size() > 0) ? exp_q.pop_front() : '0;
      check_val("dout_ch0", e[9:0], dout_ch0);
      check_val("dout_ch1", e[19:10], dout_ch1);
      check_val("dout_odd", e[20], dout_odd);
      @(posedge lclk_d4) rd_en <= 1'b1;
      @(posedge lclk_d4) rd_en <= 1'b0;
      @(negedge lclk_d4);
      guard++;
    end
    if (guard >= 64) begin
      $display("timeout: fifo never went empty while draining");
      $display("RESULT: FAIL");
      $finish;
    end
    check_true("expected entries missing from fifo", exp_q.size() == 0);
    exp_q.delete();
  endtask

  initial begin
    lclk_d4 = 1'b0;
    rst_n   = 1'b0;
    sync    = 1'b0;
    rd_en   = 1'b0;
    fclk4b  = FCLK_G1;
    din4b   = '0;
    fclk_seq = '{FCLK_G0, FCLK_G1, FCLK_G2, FCLK_G3, FCLK_G4};
    rng = 32'h05ff80b4;
    repeat (16) @(posedge lclk_d4);
    rst_n <= 1'b1;
    @(negedge lclk_d4);
    check_val("locked", 0, locked);
    check_val("empty", 1, empty);
    check_val("full", 0, full);
    check_val("fclk_err_cnt", 0, fclk_err_cnt);
    end_test("reset");

    send_frame(2, -1, -1);  // join mid-frame
    send_frame(0, -1, -1);
    @(negedge lclk_d4);
    check_val("locked", 1, locked);
    send_frame(0, -1, -1);
    send_frame(0, 1, -1);   // sync inside the frame relocks at its G4
    send_frame(0, -1, -1);
    send_frame(0, -1, -1);
    park();
    drain();
    end_test("lock_and_assembly");

    send_frame(0, -1, -1);  // relock
    send_frame(0, -1, -1);
    @(negedge lclk_d4);
    err0 = fclk_err_cnt;
    send_frame(0, -1, 2);
    send_frame(0, -1, -1);
    send_frame(0, -1, -1);
    @(negedge lclk_d4);
    check_val("fclk_err_cnt", err0 + 2, fclk_err_cnt);
    park();
    drain();
    end_test("fclk_errors");

    send_frame(0, -1, -1);
    for (int f = 0; f < 6; f++) send_frame(0, -1, -1);
    @(negedge lclk_d4);
    check_val("full", 1, full);
    park();
    drain();
    end_test("overflow");

    send_frame(0, -1, -1);
    send_frame(0, -1, -1);
    saw_unlock = 1'b0;
    send_frame(0, 1, -1);
    check_true("locked did not fall after sync", saw_unlock);
    send_frame(0, -1, -1);
    park();
    drain();
    end_test("resync");

    $display("tests passed %0d failed %0d errors %0d", tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- adc_unit_asserts.sv
`timescale 1ns/1ps

module adc_unit_asserts (
  input logic            lclk_d4,
  input logic            rst_n,
  input logic            locked,
  input adc_pkg::phase_t phase,
  input logic            pair_valid,
  input logic            empty,
  input logic            full
);

  // word phase stays inside the frame
  a_phase_range: assert property (@(posedge lclk_d4) disable iff (!rst_n) phase <= 3'd4)
    else $error("phase out of range: %0d", phase);

  // every new lock starts the frame at phase 0
  a_phase_relock: assert property (@(posedge lclk_d4) disable iff (!rst_n)
    $rose(locked) |-> phase == 3'd0)
    else $error("phase not 0 on the first locked cycle");

  // the pair strobe lands in the phase after 2 or 4
  a_pair_phase: assert property (@(posedge lclk_d4) disable iff (!rst_n)
    pair_valid |-> (phase == 3'd3 || phase == 3'd0))
    else $error("pair_valid outside the phase after 2 or 4");

  a_empty_full: assert property (@(posedge lclk_d4) disable iff (!rst_n) !(empty && full))
    else $error("fifo empty and full together");

endmodule

bind adc_unit_top adc_unit_asserts i_adc_unit_asserts (
  .lclk_d4    (lclk_d4),
  .rst_n      (rst_n),
  .locked     (locked),
  .phase      (phase),
  .pair_valid (pair_valid),
  .empty      (empty),
  .full       (full)
);

//--- adc_unit_top.sv
`timescale 1ns/1ps

module adc_unit_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic              lclk_d4,
  input  logic              rst_n,
  input  logic              sync,         // force realignment
  input  adc_pkg::group_t   fclk4b,       // deserialized frame clock
  input  logic [7:0]        din4b,        // lane 1 in 7:4, lane 0 in 3:0
  input  logic              rd_en,
  output logic              locked,
  output adc_pkg::err_cnt_t fclk_err_cnt,
  output adc_pkg::sample_t  dout_ch0,
  output adc_pkg::sample_t  dout_ch1,
  output logic              dout_odd,
  output logic              empty,
  output logic              full
);

  import adc_pkg::*;

  phase_t  phase;
  logic    pair_valid;
  sample_t ch0;
  sample_t ch1;
  logic    odd;

  frame_align_fsm i_frame_align_fsm (
    .lclk_d4 (lclk_d4),
    .rst_n   (rst_n),
    .sync    (sync),
    .fclk4b  (fclk4b),
    .locked  (locked)
  );

  word_phase_ctr i_word_phase_ctr (
    .lclk_d4 (lclk_d4),
    .rst_n   (rst_n),
    .locked  (locked),
    .phase   (phase)
  );

  lane_gearbox i_lane_gearbox (
    .lclk_d4    (lclk_d4),
    .rst_n      (rst_n),
    .phase      (phase),
    .din4b      (din4b),
    .pair_valid (pair_valid),
    .ch0        (ch0),
    .ch1        (ch1),
    .odd        (odd)
  );

  // runs whether locked or not
  fclk_monitor i_fclk_monitor (
    .lclk_d4 (lclk_d4),
    .rst_n   (rst_n),
    .fclk4b  (fclk4b),
    .err_cnt (fclk_err_cnt)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_sample_fifo (
    .lclk_d4  (lclk_d4),
    .rst_n    (rst_n),
    .wr_en    (pair_valid),
    .wr_ch0   (ch0),
    .wr_ch1   (ch1),
    .wr_odd   (odd),
    .rd_en    (rd_en),
    .dout_ch0 (dout_ch0),
    .dout_ch1 (dout_ch1),
    .dout_odd (dout_odd),
    .empty    (empty),
    .full     (full)
  );

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
  parameter int FIFO_DEPTH = 8  // power of two, 2 or more
) (
  input  logic             lclk_d4,
  input  logic             rst_n,
  input  logic             wr_en,
  input  adc_pkg::sample_t wr_ch0,
  input  adc_pkg::sample_t wr_ch1,
  input  logic             wr_odd,
  input  logic             rd_en,    // pop strobe, ignored while empty
  output adc_pkg::sample_t dout_ch0,
  output adc_pkg::sample_t dout_ch1,
  output logic             dout_odd,
  output logic             empty,
  output logic             full
);

  import adc_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int EW = 2 * $bits(sample_t) + 1; // {odd, ch1, ch0}

  logic [EW-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   cnt;      // occupancy
  logic [AW:0]   cnt_nxt;
  logic          push;
  logic          pop;

  assign push = wr_en && !full;  // newest pair lost on overflow
  assign pop  = rd_en && !empty;

  always_comb begin
    cnt_nxt = cnt;
    if (push && !pop) begin
      cnt_nxt = cnt + 1'b1;
    end else if (pop && !push) begin
      cnt_nxt = cnt - 1'b1;
    end
  end

  always_ff @(posedge lclk_d4) begin
    if (push) begin
      mem[wr_ptr] <= {wr_odd, wr_ch1, wr_ch0};
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge lclk_d4 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      cnt   <= cnt_nxt;
      empty <= (cnt_nxt == '0);
      full  <= (cnt_nxt == (AW+1)'(FIFO_DEPTH));
    end
  end

  // show-ahead head
  assign {dout_odd, dout_ch1, dout_ch0} = mem[rd_ptr];

endmodule

//--- lane_gearbox.sv
`timescale 1ns/1ps

module lane_gearbox (
  input  logic             lclk_d4,
  input  logic             rst_n,
  input  adc_pkg::phase_t  phase,
  input  logic [7:0]       din4b,      // lane 1 in 7:4, lane 0 in 3:0
  output logic             pair_valid, // one pulse per finished pair
  output adc_pkg::sample_t ch0,
  output adc_pkg::sample_t ch1,
  output logic             odd         // high for the d1 stream
);

  import adc_pkg::*;

  group_t  grp  [2];  // per lane group of this cycle
  sample_t d0_q [2];  // even word holding regs
  sample_t d1_q [2];  // odd word holding regs

  assign grp[0] = din4b[3:0];
  assign grp[1] = din4b[7:4];

  // slice loading, lsb first
  // d0 spans phases 0..2, d1 starts in the upper half of phase 2
  always_ff @(posedge lclk_d4) begin
    for (int i = 0; i < 2; i++) begin
      case (phase)
        3'd0: d0_q[i][3:0] <= grp[i];
        3'd1: d0_q[i][7:4] <= grp[i];
        3'd2: begin
          d0_q[i][9:8] <= grp[i][1:0]; // d0 complete
          d1_q[i][1:0] <= grp[i][3:2]; // d1 begins
        end
        3'd3: d1_q[i][5:2] <= grp[i];
        PHASE_LAST: d1_q[i][9:6] <= grp[i]; // d1 complete
        default: begin
        end
      endcase
    end
  end

  // strobe lands the same cycle the finished word is in the holding reg
  always_ff @(posedge lclk_d4 or negedge rst_n) begin
    if (!rst_n) begin
      pair_valid <= 1'b0;
      odd        <= 1'b0;
    end else begin
      pair_valid <= (phase == 3'd2) || (phase == PHASE_LAST);
      if (phase == 3'd2) begin
        odd <= 1'b0;
      end else if (phase == PHASE_LAST) begin
        odd <= 1'b1;
      end
    end
  end

  // d0 is stable until the next phase 0, d1 until the next phase 2
  assign ch0 = odd ? d1_q[0] : d0_q[0];
  assign ch1 = odd ? d1_q[1] : d0_q[1];

endmodule

//--- fclk_monitor.sv
`timescale 1ns/1ps

module fclk_monitor (
  input  logic              lclk_d4,
  input  logic              rst_n,
  input  adc_pkg::group_t   fclk4b,
  output adc_pkg::err_cnt_t err_cnt
);

  import adc_pkg::*;

  group_t   fclk_q1;  // newest registered group
  group_t   fclk_q2;  // the one before it
  logic [1:0] vld;    // both stages hold real groups once vld[1] is set
  group_t   pred;     // expected predecessor of fclk_q1
  logic     legal;    // fclk_q1 is one of the five groups
  err_cnt_t cnt;

  always_ff @(posedge lclk_d4) begin
    fclk_q1 <= fclk4b;
    fclk_q2 <= fclk_q1;
  end

  // pipeline fill after reset, keeps stale groups out of the count
  always_ff @(posedge lclk_d4 or negedge rst_n) begin
    if (!rst_n) begin
      vld <= 2'b00;
    end else begin
      vld <= {vld[0], 1'b1};
    end
  end

  // sequence is G0 G1 G2 G3 G4 then G0 again
  always_comb begin
    legal = 1'b1;
    pred  = FCLK_G3;
    case (fclk_q1)
      FCLK_G0: pred = FCLK_G4;
      FCLK_G1: pred = FCLK_G0;
      FCLK_G2: pred = FCLK_G1;
      FCLK_G3: pred = FCLK_G2;
      FCLK_G4: pred = FCLK_G3;
      default: legal = 1'b0;  // anything else is a broken frame clock
    endcase
  end

  // one illegal group costs 2, once for itself and once as a bad predecessor
  always_ff @(posedge lclk_d4 or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (vld[1] && (!legal || (fclk_q2 != pred))) begin
      cnt <= cnt + 1'b1;  // wraps naturally
    end
  end

  assign err_cnt = cnt;

endmodule

//--- word_phase_ctr.sv
`timescale 1ns/1ps

module word_phase_ctr (
  input  logic            lclk_d4,
  input  logic            rst_n,
  input  logic            locked,
  output adc_pkg::phase_t phase
);

  import adc_pkg::*;

  phase_t cnt; // running modulo-5 count

  // parked at 0 while unlocked, so the first locked cycle is phase 0
  always_ff @(posedge lclk_d4 or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!locked) begin
      cnt <= '0;
    end else if (cnt == PHASE_LAST) begin
      cnt <= '0;            // frame done, wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // forced to 0 right away when lock drops, e.g. one cycle after sync
  assign phase = locked ? cnt : '0;

endmodule

//--- frame_align_fsm.sv
`timescale 1ns/1ps

module frame_align_fsm (
  input  logic            lclk_d4,
  input  logic            rst_n,
  input  logic            sync,     // restart the hunt
  input  adc_pkg::group_t fclk4b,   // deserialized frame clock
  output logic            locked
);

  import adc_pkg::*;

  align_state_t state;
  align_state_t state_nxt;

  // boundary search
  // the last group of a frame marks the edge, the next cycle starts a word
  always_comb begin
    state_nxt = state;
    case (state)
      HUNT: begin
        if (fclk4b == FCLK_G4) begin
          state_nxt = LOCKED; // next cycle carries FCLK_G0 and the first data bits
        end
      end
      LOCKED: begin
        state_nxt = LOCKED; // held, fclk_monitor watches for slips
      end
      default: begin
        state_nxt = HUNT;
      end
    endcase
    if (sync) begin
      state_nxt = HUNT;   // sync wins over everything
    end
  end

  always_ff @(posedge lclk_d4 or negedge rst_n) begin
    if (!rst_n) begin
      state <= HUNT;
    end else begin
      state <= state_nxt;
    end
  end

  assign locked = (state == LOCKED);

endmodule

//--- adc_pkg.sv
package adc_pkg;

  // one converter sample, 10 bits, sent lsb first on its lane
  typedef logic [9:0] sample_t;

  // one deserialized 4-bit group of a data lane or of the frame clock
  typedef logic [3:0] group_t;

  // word phase within a frame, 0 to 4
  typedef logic [2:0] phase_t;

  // frame clock error count, wraps at 2^32
  typedef logic [31:0] err_cnt_t;

  // frame alignment states
  typedef enum logic {
    HUNT,   // looking for the last group of a frame
    LOCKED  // boundary found, phase counter runs
  } align_state_t;

  // legal frame clock groups in arrival order
  localparam group_t FCLK_G0 = 4'b1111; // first group, first data bits
  localparam group_t FCLK_G1 = 4'b0001;
  localparam group_t FCLK_G2 = 4'b1100;
  localparam group_t FCLK_G3 = 4'b0111;
  localparam group_t FCLK_G4 = 4'b0000; // last group of a frame

  // last phase of a frame, two samples per lane are done here
  localparam phase_t PHASE_LAST = 3'd4;

endpackage
